//--- video_pkg.sv
//####################################################################
// pixel, palette and colour definitions shared by the colour mixer
// import with video_pkg::* in any module on the pixel path
//####################################################################
`default_nettype none

package video_pkg;

    // layer pixel widths, msb is the priority field
    localparam int CHAR_W = 7;     // prio, 6 bits palette and colour
    localparam int SCR_W  = 11;    // prio, 10 bits palette and colour
    localparam int OBJ_W  = 12;    // 2 bit level, 10 bits palette and colour

    localparam int NUM_LAYERS = 4; // width of gfx_en

    // palette memory
    localparam int PAL_AW    = 11;            // bit 10 selects the sprite half
    localparam int PAL_DW    = 16;            // bits 14:0 carry colour
    localparam int PAL_BW    = PAL_DW / 8;    // byte lanes per word
    localparam int PAL_DEPTH = 1 << PAL_AW;   // 2048 words

    // sprite level that beats each tile layer
    localparam logic [1:0] OBJ_LVL_CHAR = 2'd3;
    localparam logic [1:0] OBJ_LVL_SCR1 = 2'd2;
    localparam logic [1:0] OBJ_LVL_SCR2 = 2'd1;

    // colour word layout
    // each channel has a 4 bit upper part and one extra low bit
    localparam int COL_W = 5;      // output channel width
    localparam int R_POS = 0;      // red upper bits 3:0
    localparam int G_POS = 4;      // green upper bits 7:4
    localparam int B_POS = 8;      // blue upper bits 11:8
    localparam int R_LSB = 12;
    localparam int G_LSB = 13;
    localparam int B_LSB = 14;

    // bit positions inside gfx_en
    typedef enum logic [1:0] {
        layer_char = 2'd0,
        layer_scr1 = 2'd1,
        layer_scr2 = 2'd2,
        layer_obj  = 2'd3
    } layer_e;

endpackage

`default_nettype wire

//--- bus_pkg.sv
//####################################################################
// Wishbone widths and slave FSM states for the palette CPU port
// import with bus_pkg::* in the slave and the top level
//####################################################################
`default_nettype none

package bus_pkg;

    localparam int WB_AW = 11;     // word address, one palette entry each
    localparam int WB_DW = 16;     // data bus
    localparam int WB_SW = 2;      // byte selects, one per lane

    // slave FSM
    // writes go idle -> ack
    // reads go idle -> read -> ack, one extra cycle for the RAM
    typedef enum logic [1:0] {
        wb_idle = 2'd0,
        wb_read = 2'd1,
        wb_ack  = 2'd2
    } wb_state_e;

endpackage

`default_nettype wire

//--- palette_ram.sv
//####################################################################
// palette memory, 2048 x 16
// cpu side reads and byte-writes, video side only reads
// both read ports are registered, one clk of latency
//####################################################################
`timescale 1ns/1ps
`default_nettype none

module palette_ram import video_pkg::*; (
    input  wire              clk,

    // cpu port
    input  wire [PAL_AW-1:0] cpu_addr,
    input  wire [PAL_DW-1:0] cpu_data,
    input  wire [PAL_BW-1:0] cpu_we,     // one enable per byte lane
    output logic [PAL_DW-1:0] cpu_q,

    // video port
    input  wire [PAL_AW-1:0] pal_addr,
    output logic [PAL_DW-1:0] pal_q
);

    logic [PAL_DW-1:0] mem [PAL_DEPTH];

    // cpu side
    // read and write share the edge, so q returns the old word
    always_ff @(posedge clk) begin
        for (int b = 0; b < PAL_BW; b++) begin
            if (cpu_we[b]) begin
                mem[cpu_addr][b*8 +: 8] <= cpu_data[b*8 +: 8];   // lane b only
            end
        end
        cpu_q <= mem[cpu_addr];
    end

    // video side, read every clk
    // address is stable for a whole pixel, so any clk in the pixel works
    always_ff @(posedge clk) begin
        pal_q <= mem[pal_addr];
    end

endmodule

`default_nettype wire

//--- pal_wb_slave.sv
//####################################################################
// Wishbone classic slave in front of the palette cpu port
// write ack one cycle after stb, read ack two cycles after stb
// ack is always a single registered pulse
//####################################################################
`timescale 1ns/1ps
`default_nettype none

module pal_wb_slave import bus_pkg::*; (
    input  wire              clk,
    input  wire              rst_n,

    // bus side
    input  wire              wb_cyc,
    input  wire              wb_stb,
    input  wire              wb_we,
    input  wire [WB_AW-1:0]  wb_adr,
    input  wire [WB_DW-1:0]  wb_dat_w,
    input  wire [WB_SW-1:0]  wb_sel,
    output logic [WB_DW-1:0] wb_dat_r,
    output logic             wb_ack,

    // palette ram side
    output logic [WB_AW-1:0] cpu_addr,
    output logic [WB_DW-1:0] cpu_data,
    output logic [WB_SW-1:0] cpu_we,
    input  wire [WB_DW-1:0]  cpu_q
);

    wb_state_e state;
    logic      accept;     // new cycle taken this clk

    assign accept = (state == wb_idle) && wb_cyc && wb_stb;

    // master holds adr and data until ack, so they go straight to the ram
    assign cpu_addr = wb_adr;
    assign cpu_data = wb_dat_w;
    assign cpu_we   = (accept && wb_we) ? wb_sel : '0;   // strobe on accept only

    // the ack port hides the enum literal, hence bus_pkg::wb_ack below
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state  <= wb_idle;
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= 1'b0;                 // default low, pulse below
            case (state)
                wb_idle: begin
                    if (accept) begin
                        if (wb_we) begin
                            state  <= bus_pkg::wb_ack;   // ram written on this edge
                            wb_ack <= 1'b1;
                        end else begin
                            state <= wb_read;            // wait for cpu_q
                        end
                    end
                end
                wb_read: begin
                    state  <= bus_pkg::wb_ack;
                    wb_ack <= 1'b1;
                end
                bus_pkg::wb_ack: begin
                    state <= wb_idle;                    // master drops stb now
                end
                default: state <= wb_idle;
            endcase
        end
    end

    // cpu_q holds the word addressed since the accept edge
    always_ff @(posedge clk) begin
        if (state == wb_read) begin
            wb_dat_r <= cpu_q;              // held through the ack cycle
        end
    end

endmodule

`default_nettype wire

//--- layer_prio.sv
//####################################################################
// layer enable gating and sprite against tile priority
// one registered candidate per tile layer, then a front to back pick
// pal_addr follows the candidates combinationally
//####################################################################
`timescale 1ns/1ps
`default_nettype none

module layer_prio import video_pkg::*; (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire                  pxl_cen,
    input  wire [NUM_LAYERS-1:0] gfx_en,
    input  wire [CHAR_W-1:0]     char_pxl,
    input  wire [SCR_W-1:0]      scr1_pxl,
    input  wire [SCR_W-1:0]      scr2_pxl,
    input  wire [OBJ_W-1:0]      obj_pxl,
    output logic [PAL_AW-1:0]    pal_addr
);

    logic [CHAR_W-1:0] char_g;           // gated layers
    logic [SCR_W-1:0]  scr1_g;
    logic [SCR_W-1:0]  scr2_g;
    logic [OBJ_W-1:0]  obj_g;
    logic [1:0]        obj_lvl;
    logic [PAL_AW-1:0] cand_char;        // registered candidates
    logic [PAL_AW-1:0] cand_scr1;
    logic [PAL_AW-1:0] cand_scr2;

    // sprite wins if opaque, at the right level and the tile is not in front
    function automatic logic [PAL_AW-1:0] pick_cand(
        input logic [PAL_AW-2:0] obj,
        input logic [PAL_AW-2:0] tile,
        input logic              tile_prio,
        input logic              lvl_hit
    );
        logic obj_opaque;
        obj_opaque = obj[3:0] != 4'd0;
        if (obj_opaque && lvl_hit && !tile_prio) begin
            pick_cand = {1'b1, obj};     // sprite half of palette
        end else begin
            pick_cand = {1'b0, tile};
        end
    endfunction

    // sprites use 4 colour bits, tiles only 3
    function automatic logic is_opaque(input logic [PAL_AW-1:0] cand);
        if (cand[PAL_AW-1]) begin
            is_opaque = cand[3:0] != 4'd0;
        end else begin
            is_opaque = cand[2:0] != 3'd0;
        end
    endfunction

    // disabled layer reads as colour 0, i.e. transparent
    always_comb begin
        char_g = char_pxl;
        scr1_g = scr1_pxl;
        scr2_g = scr2_pxl;
        obj_g  = obj_pxl;
        if (!gfx_en[layer_char]) char_g[3:0] = 4'd0;
        if (!gfx_en[layer_scr1]) scr1_g[3:0] = 4'd0;
        if (!gfx_en[layer_scr2]) scr2_g[3:0] = 4'd0;
        if (!gfx_en[layer_obj])  obj_g[3:0]  = 4'd0;
    end

    assign obj_lvl = obj_g[OBJ_W-1 -: 2];   // level field, never gated

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cand_char <= '0;
            cand_scr1 <= '0;
            cand_scr2 <= '0;
        end else if (pxl_cen) begin
            // char tile index padded with zeros up to 10 bits
            cand_char <= pick_cand(obj_g[PAL_AW-2:0],
                                   {{(PAL_AW-CHAR_W){1'b0}}, char_g[CHAR_W-2:0]},
                                   char_g[CHAR_W-1], obj_lvl == OBJ_LVL_CHAR);
            cand_scr1 <= pick_cand(obj_g[PAL_AW-2:0], scr1_g[SCR_W-2:0],
                                   scr1_g[SCR_W-1], obj_lvl == OBJ_LVL_SCR1);
            cand_scr2 <= pick_cand(obj_g[PAL_AW-2:0], scr2_g[SCR_W-2:0],
                                   scr2_g[SCR_W-1], obj_lvl == OBJ_LVL_SCR2);
        end
    end

    // char in front, scr2 is the backdrop and always shows
    always_comb begin
        if (is_opaque(cand_char)) begin
            pal_addr = cand_char;
        end else if (is_opaque(cand_scr1)) begin
            pal_addr = cand_scr1;
        end else begin
            pal_addr = cand_scr2;
        end
    end

endmodule

`default_nettype wire

//--- video_out.sv
//####################################################################
// palette word to 5 bit rgb, with blanking
// lhbl and lvbl delayed two pixels to line up with the colour
//####################################################################
`timescale 1ns/1ps
`default_nettype none

module video_out import video_pkg::*; (
    input  wire               clk,
    input  wire               rst_n,
    input  wire               pxl_cen,
    input  wire               lhbl,
    input  wire               lvbl,
    input  wire [PAL_DW-1:0]  pal_q,
    output logic [COL_W-1:0]  red,
    output logic [COL_W-1:0]  green,
    output logic [COL_W-1:0]  blue,
    output logic              lhbl_dly,
    output logic              lvbl_dly
);

    logic [1:0]       lhbl_sr;           // two pixel delay lines
    logic [1:0]       lvbl_sr;
    logic [COL_W-1:0] red_c;             // unpacked palette word
    logic [COL_W-1:0] green_c;
    logic [COL_W-1:0] blue_c;
    logic             vis;               // pixel being registered is visible

    // upper 4 bits then the extra low bit, per channel
    assign red_c   = {pal_q[R_POS +: COL_W-1], pal_q[R_LSB]};
    assign green_c = {pal_q[G_POS +: COL_W-1], pal_q[G_LSB]};
    assign blue_c  = {pal_q[B_POS +: COL_W-1], pal_q[B_LSB]};

    // stage 0 moves to the _dly outputs on the same edge as the colour
    assign vis = lhbl_sr[0] && lvbl_sr[0];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            lhbl_sr <= 2'b00;
            lvbl_sr <= 2'b00;
            red     <= '0;
            green   <= '0;
            blue    <= '0;
        end else if (pxl_cen) begin
            lhbl_sr <= {lhbl_sr[0], lhbl};
            lvbl_sr <= {lvbl_sr[0], lvbl};
            if (vis) begin
                red   <= red_c;
                green <= green_c;
                blue  <= blue_c;
            end else begin
                red   <= '0;              // blanked
                green <= '0;
                blue  <= '0;
            end
        end
    end

    assign lhbl_dly = lhbl_sr[1];
    assign lvbl_dly = lvbl_sr[1];

endmodule

`default_nettype wire

//--- colmix.sv
//####################################################################
// colour mixer top, four layers in, 15 bit rgb out
// cpu reaches the palette through a Wishbone classic slave port
// colour and delayed blanking come out 2 pxl_cen edges after the layers
//####################################################################
`timescale 1ns/1ps
`default_nettype none

module colmix import video_pkg::*; import bus_pkg::*; (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire                  pxl_cen,     // at most every second clk
    input  wire [NUM_LAYERS-1:0] gfx_en,      // debug layer enables

    input  wire                  lhbl,
    input  wire                  lvbl,

    // layer pixels
    input  wire [CHAR_W-1:0]     char_pxl,
    input  wire [SCR_W-1:0]      scr1_pxl,
    input  wire [SCR_W-1:0]      scr2_pxl,
    input  wire [OBJ_W-1:0]      obj_pxl,

    // Wishbone slave
    input  wire                  wb_cyc,
    input  wire                  wb_stb,
    input  wire                  wb_we,
    input  wire [WB_AW-1:0]      wb_adr,
    input  wire [WB_DW-1:0]      wb_dat_w,
    input  wire [WB_SW-1:0]      wb_sel,
    output logic [WB_DW-1:0]     wb_dat_r,
    output logic                 wb_ack,

    // video out
    output logic [COL_W-1:0]     red,
    output logic [COL_W-1:0]     green,
    output logic [COL_W-1:0]     blue,
    output logic                 lhbl_dly,
    output logic                 lvbl_dly
);

    logic [WB_AW-1:0]  cpu_addr;         // slave to ram
    logic [WB_DW-1:0]  cpu_data;
    logic [WB_SW-1:0]  cpu_we;
    logic [WB_DW-1:0]  cpu_q;            // ram to slave
    logic [PAL_AW-1:0] pal_addr;         // priority to ram
    logic [PAL_DW-1:0] pal_q;            // ram to output stage

    pal_wb_slave u_wb (
        .clk      (clk),
        .rst_n    (rst_n),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_sel   (wb_sel),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .cpu_addr (cpu_addr),
        .cpu_data (cpu_data),
        .cpu_we   (cpu_we),
        .cpu_q    (cpu_q)
    );

    layer_prio u_prio (
        .clk      (clk),
        .rst_n    (rst_n),
        .pxl_cen  (pxl_cen),
        .gfx_en   (gfx_en),
        .char_pxl (char_pxl),
        .scr1_pxl (scr1_pxl),
        .scr2_pxl (scr2_pxl),
        .obj_pxl  (obj_pxl),
        .pal_addr (pal_addr)
    );

    palette_ram u_pal (
        .clk      (clk),
        .cpu_addr (cpu_addr),
        .cpu_data (cpu_data),
        .cpu_we   (cpu_we),
        .cpu_q    (cpu_q),
        .pal_addr (pal_addr),
        .pal_q    (pal_q)
    );

    video_out u_out (
        .clk      (clk),
        .rst_n    (rst_n),
        .pxl_cen  (pxl_cen),
        .lhbl     (lhbl),
        .lvbl     (lvbl),
        .pal_q    (pal_q),
        .red      (red),
        .green    (green),
        .blue     (blue),
        .lhbl_dly (lhbl_dly),
        .lvbl_dly (lvbl_dly)
    );

endmodule

`default_nettype wire

//--- tb_colmix.sv
//####################################################################
// self-checking testbench for the colour mixer
// preloads the palette over Wishbone, then runs a pixel table
//####################################################################
`timescale 1ns/1ps
`default_nettype none

module tb_colmix
    import video_pkg::*;
    import bus_pkg::*;
();

    localparam int CLK_PERIOD      = 100;
    localparam int NUM_ROWS        = 24;
    localparam int WATCHDOG_CYCLES = PAL_DEPTH * 6 + NUM_ROWS * 8 + 100;

    logic                  clk;
    logic                  rst_n;
    logic                  pxl_cen;
    logic [NUM_LAYERS-1:0] gfx_en;
    logic                  lhbl;
    logic                  lvbl;
    logic [CHAR_W-1:0]     char_pxl;
    logic [SCR_W-1:0]      scr1_pxl;
    logic [SCR_W-1:0]      scr2_pxl;
    logic [OBJ_W-1:0]      obj_pxl;
    logic                  wb_cyc;
    logic                  wb_stb;
    logic                  wb_we;
    logic [WB_AW-1:0]      wb_adr;
    logic [WB_DW-1:0]      wb_dat_w;
    logic [WB_SW-1:0]      wb_sel;
    logic [WB_DW-1:0]      wb_dat_r;
    logic                  wb_ack;
    logic [COL_W-1:0]      red;
    logic [COL_W-1:0]      green;
    logic [COL_W-1:0]      blue;
    logic                  lhbl_dly;
    logic                  lvbl_dly;

    logic [PAL_DW-1:0]     shadow [PAL_DEPTH];    // what the palette should hold
    integer                seed;
    int                    errors;
    int                    checks;

    // pixel table, one entry per row, expected palette address worked out by hand
    logic [NUM_LAYERS-1:0] row_en   [NUM_ROWS];
    logic                  row_hb   [NUM_ROWS];
    logic                  row_vb   [NUM_ROWS];
    logic [CHAR_W-1:0]     row_char [NUM_ROWS];
    logic [SCR_W-1:0]      row_scr1 [NUM_ROWS];
    logic [SCR_W-1:0]      row_scr2 [NUM_ROWS];
    logic [OBJ_W-1:0]      row_obj  [NUM_ROWS];
    logic [PAL_AW-1:0]     row_addr [NUM_ROWS];
    int                    nrows;

    colmix u_colmix (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    // pixel enable on every second clk, moves with the other inputs
    always @(posedge clk) begin
        #10;
        pxl_cen = ~pxl_cen;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: run did not finish within %0d clk cycles", WATCHDOG_CYCLES);
        $display("TEST FAIL");
        $finish;
    end

    task automatic check_eq(input string name, input logic [15:0] got,
                            input logic [15:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic add_row(input logic [3:0] en, input logic hb, input logic vb,
                           input logic [6:0] ch, input logic [10:0] s1,
                           input logic [10:0] s2, input logic [11:0] ob,
                           input logic [10:0] addr);
        row_en[nrows]   = en;
        row_hb[nrows]   = hb;
        row_vb[nrows]   = vb;
        row_char[nrows] = ch;
        row_scr1[nrows] = s1;
        row_scr2[nrows] = s2;
        row_obj[nrows]  = ob;
        row_addr[nrows] = addr;
        nrows++;
    endtask

    // one Wishbone cycle, entered and left 10 ns after a clk edge
    task automatic bus_cycle(input logic we, input logic [10:0] adr,
                             input logic [15:0] dat, input logic [1:0] sel,
                             output logic [15:0] rdata);
        int n;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = dat;
        wb_sel   = sel;
        @(posedge clk);
        #10;
        n = 1;
        while (wb_ack !== 1'b1 && n < 8) begin    // bounded wait for ack
            @(posedge clk);
            #10;
            n++;
        end
        checks++;
        assert (wb_ack === 1'b1) else begin
            errors++;
            $display("bus cycle at address %h never got an ack", adr);
        end
        check_eq("ack latency", n, we ? 1 : 2);   // writes 1 cycle, reads 2
        rdata  = wb_dat_r;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        @(posedge clk);
        #10;
        check_eq("wb_ack after pulse", wb_ack, 1'b0);   // single cycle only
    endtask

    task automatic pxl_edge();
        @(posedge clk);
        while (!pxl_cen) @(posedge clk);
    endtask

    // colour and delayed blanking for one palette word and blanking pair
    task automatic check_pixel(input logic [PAL_DW-1:0] w, input logic hb,
                               input logic vb);
        logic vis;
        vis = hb && vb;
        check_eq("red", red, vis ? {w[3:0], w[12]} : 5'd0);
        check_eq("green", green, vis ? {w[7:4], w[13]} : 5'd0);
        check_eq("blue", blue, vis ? {w[11:8], w[14]} : 5'd0);
        check_eq("lhbl_dly", lhbl_dly, hb);
        check_eq("lvbl_dly", lvbl_dly, vb);
    endtask

    initial begin
        logic [WB_DW-1:0]  rd;
        logic [WB_DW-1:0]  wd;
        logic [WB_AW-1:0]  adr;
        logic [WB_SW-1:0]  sel;
        logic [PAL_DW-1:0] w;
        logic [PAL_DW-1:0] prev_w;
        logic              prev_hb;
        logic              prev_vb;
        clk      = 1'b0;
        rst_n    = 1'b0;
        pxl_cen  = 1'b0;
        gfx_en   = 4'hf;
        lhbl     = 1'b0;
        lvbl     = 1'b0;
        char_pxl = '0;
        scr1_pxl = '0;
        scr2_pxl = '0;
        obj_pxl  = '0;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        wb_sel   = '0;
        seed     = 96468;
        errors   = 0;
        checks   = 0;
        nrows    = 0;

        // en    hb vb  char   scr1     scr2     obj      address
        add_row(4'hf, 1, 1, 7'h15, 11'h123, 11'h2a6, 12'h3c7, 11'h015);  // level 0 sprite
        add_row(4'hf, 1, 1, 7'h15, 11'h123, 11'h2a6, 12'hfc7, 11'h7c7);  // level 3 over char
        add_row(4'hf, 1, 1, 7'h55, 11'h123, 11'h2a6, 12'hfc7, 11'h015);  // char prio wins
        add_row(4'hf, 1, 1, 7'h18, 11'h123, 11'h2a6, 12'hfc7, 11'h7c7);
        add_row(4'hf, 1, 1, 7'h15, 11'h123, 11'h2a6, 12'hbc7, 11'h015);  // char above level 2
        add_row(4'hf, 1, 1, 7'h18, 11'h123, 11'h2a6, 12'hbc7, 11'h7c7);
        add_row(4'hf, 1, 1, 7'h18, 11'h523, 11'h2a6, 12'hbc7, 11'h123);  // scr1 prio
        add_row(4'hf, 1, 1, 7'h18, 11'h128, 11'h2a6, 12'hbc7, 11'h7c7);
        add_row(4'hf, 1, 1, 7'h18, 11'h123, 11'h2a6, 12'h7c7, 11'h123);  // scr1 above level 1
        add_row(4'hf, 1, 1, 7'h18, 11'h128, 11'h2a6, 12'h7c7, 11'h7c7);
        add_row(4'hf, 1, 1, 7'h18, 11'h128, 11'h6a6, 12'h7c7, 11'h2a6);  // scr2 prio
        add_row(4'hf, 1, 1, 7'h18, 11'h128, 11'h2b0, 12'h7c7, 11'h7c7);
        add_row(4'hf, 1, 1, 7'h15, 11'h123, 11'h2a6, 12'hfc0, 11'h015);  // clear sprite
        add_row(4'hf, 1, 1, 7'h18, 11'h123, 11'h2a6, 12'hfc0, 11'h123);
        add_row(4'hf, 1, 1, 7'h18, 11'h128, 11'h2b0, 12'h3c0, 11'h2b0);  // backdrop only
        add_row(4'hf, 1, 1, 7'h18, 11'h128, 11'h2a6, 12'h3c7, 11'h2a6);
        add_row(4'he, 1, 1, 7'h15, 11'h123, 11'h2a6, 12'h3c7, 11'h123);  // char off
        add_row(4'h7, 1, 1, 7'h18, 11'h123, 11'h2a6, 12'hfc7, 11'h123);  // sprites off
        add_row(4'hd, 1, 1, 7'h18, 11'h123, 11'h2a6, 12'h3c7, 11'h2a6);  // scr1 off
        add_row(4'hb, 1, 1, 7'h18, 11'h128, 11'h2a6, 12'h3c7, 11'h2a0);  // scr2 off
        add_row(4'h7, 1, 1, 7'h18, 11'h128, 11'h2a6, 12'h7c7, 11'h2a6);
        add_row(4'hf, 0, 1, 7'h15, 11'h123, 11'h2a6, 12'h3c7, 11'h015);  // hblank
        add_row(4'hf, 1, 0, 7'h15, 11'h123, 11'h2a6, 12'hfc7, 11'h7c7);  // vblank
        add_row(4'hf, 0, 0, 7'h18, 11'h128, 11'h2a6, 12'h3c7, 11'h2a6);

        repeat (4) @(posedge clk);
        #10;
        rst_n = 1'b1;
        check_eq("wb_ack", wb_ack, 1'b0);
        check_eq("red", red, '0);
        check_eq("green", green, '0);
        check_eq("blue", blue, '0);
        check_eq("lhbl_dly", lhbl_dly, 1'b0);
        check_eq("lvbl_dly", lvbl_dly, 1'b0);

        // full palette fill, then read it all back
        for (int i = 0; i < PAL_DEPTH; i++) begin
            wd        = $random(seed);
            shadow[i] = wd;
            bus_cycle(1'b1, i, wd, 2'b11, rd);
        end
        for (int i = 0; i < PAL_DEPTH; i++) begin
            bus_cycle(1'b0, i, '0, 2'b11, rd);
            check_eq("wb_dat_r", rd, shadow[i]);
        end

        // single lane writes on entries the pixel rows look up
        for (int k = 0; k < 6; k++) begin
            adr = row_addr[k * 4];
            sel = (k % 2 == 1) ? 2'b10 : 2'b01;
            wd  = $random(seed);
            bus_cycle(1'b1, adr, wd, sel, rd);
            if (sel[0]) shadow[adr][7:0] = wd[7:0];
            if (sel[1]) shadow[adr][15:8] = wd[15:8];
            bus_cycle(1'b0, adr, '0, 2'b11, rd);
            check_eq("wb_dat_r", rd, shadow[adr]);
        end

        // blanking inputs were low so far, outputs start out blank
        prev_w  = '0;
        prev_hb = 1'b0;
        prev_vb = 1'b0;

        // each row held for two pixels
        // first edge still shows the previous row, result valid after the second
        for (int i = 0; i < nrows; i++) begin
            gfx_en   = row_en[i];
            lhbl     = row_hb[i];
            lvbl     = row_vb[i];
            char_pxl = row_char[i];
            scr1_pxl = row_scr1[i];
            scr2_pxl = row_scr2[i];
            obj_pxl  = row_obj[i];
            pxl_edge();
            #10;
            check_pixel(prev_w, prev_hb, prev_vb);
            pxl_edge();
            #10;
            w = shadow[row_addr[i]];
            check_pixel(w, row_hb[i], row_vb[i]);
            prev_w  = w;
            prev_hb = row_hb[i];
            prev_vb = row_vb[i];
        end

        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
video_pkg.sv
bus_pkg.sv
palette_ram.sv
pal_wb_slave.sv
layer_prio.sv
video_out.sv
colmix.sv
tb_colmix.sv
